// ==== sim.f ====
source/ctr_isa_pkg.sv
source/ctr_obs_pkg.sv
source/ctr_lsu_addr.sv
source/ctr_branch_cmp.sv
source/ctr_decode.sv
source/ctr_execute.sv
source/ctr_observer.sv
tb/tb_clock_gen.sv
tb/tb_ctr_observer.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ctr_observer
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_ctr_observer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ctr_observer;

	localparam int N_ITEMS        = 400;
	localparam int N_FULL_READY   = 100;
	localparam int TIMEOUT_CYCLES = N_ITEMS * 8 + 100;

	typedef struct packed {
		logic [31:0] pc;
		logic [2:0]  cls;
		logic [31:0] addr;
		logic        split;
		logic        taken;
		logic        div_zero;
		int          accept_cycle;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] instr;
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic [31:0] pc;
	logic        obs_valid;
	logic        obs_ready;
	logic [31:0] obs_pc;
	logic [2:0]  obs_class;
	logic [31:0] obs_addr;
	logic        obs_split;
	logic        obs_taken;
	logic        obs_div_zero;

	integer      seed = 39;
	int          cycle_count = 0;
	int          n_sent = 0;
	int          n_received = 0;
	logic [31:0] next_pc = 32'h0000_1000;
	expect_t     expected_q[$];

	tb_clock_gen u_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	ctr_observer dut_i (
		.clk_i          (clk),
		.rst_n_i        (rst_n),
		.in_valid_i     (in_valid),
		.in_ready_o     (in_ready),
		.instr_i        (instr),
		.rs1_i          (rs1),
		.rs2_i          (rs2),
		.pc_i           (pc),
		.obs_valid_o    (obs_valid),
		.obs_ready_i    (obs_ready),
		.obs_pc_o       (obs_pc),
		.obs_class_o    (obs_class),
		.obs_addr_o     (obs_addr),
		.obs_split_o    (obs_split),
		.obs_taken_o    (obs_taken),
		.obs_div_zero_o (obs_div_zero)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// reference model built from the RV32 field layout
	function automatic expect_t predict(input logic [31:0] word, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] at_pc);
		expect_t     e;
		logic [6:0]  opcode;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] offs;
		logic        cond;
		opcode = word[6:0];
		f3     = word[14:12];
		f7     = word[31:25];
		offs   = 32'd0;
		e      = '0;
		e.pc   = at_pc;
		e.cls  = ctr_obs_pkg::CLS_OTHER;
		if (opcode == ctr_isa_pkg::OPC_LOAD) begin
			e.cls = ctr_obs_pkg::CLS_LOAD;
			offs  = {{20{word[31]}}, word[31:20]};
		end else if (opcode == ctr_isa_pkg::OPC_STORE) begin
			e.cls = ctr_obs_pkg::CLS_STORE;
			offs  = {{20{word[31]}}, word[31:25], word[11:7]};
		end else if (opcode == ctr_isa_pkg::OPC_BRANCH) begin
			e.cls = ctr_obs_pkg::CLS_BRANCH;
		end else if (opcode == ctr_isa_pkg::OPC_OP && f7 == 7'h01) begin
			// mulh and mulhsu/mulhu stay other
			if (f3 == 3'b000) begin
				e.cls = ctr_obs_pkg::CLS_MUL;
			end else if (f3 >= 3'b100) begin
				e.cls = ctr_obs_pkg::CLS_DIV;
			end
		end
		e.addr = a + offs;
		if (e.cls == ctr_obs_pkg::CLS_LOAD || e.cls == ctr_obs_pkg::CLS_STORE) begin
			case (f3[1:0])
				2'b00:   e.split = 1'b0;
				2'b01:   e.split = (e.addr[1:0] == 2'b11);
				default: e.split = (e.addr[1:0] != 2'b00);
			endcase
		end
		case (f3)
			3'b001:  cond = (a != b);
			3'b100:  cond = ($signed(a) < $signed(b));
			3'b101:  cond = ($signed(a) >= $signed(b));
			3'b110:  cond = (a < b);
			3'b111:  cond = (a >= b);
			default: cond = (a == b);
		endcase
		e.taken    = (e.cls == ctr_obs_pkg::CLS_BRANCH) && cond;
		e.div_zero = (e.cls == ctr_obs_pkg::CLS_DIV) && (b == 32'd0);
		return e;
	endfunction

	task automatic make_item(output logic [31:0] word, output logic [31:0] a,
			output logic [31:0] b);
		int pick;
		word = $random(seed);
		a    = $random(seed);
		b    = $random(seed);
		pick = {$random(seed)} % 4;
		case (pick)
			0: word[6:0] = ctr_isa_pkg::OPC_LOAD;
			1: word[6:0] = ctr_isa_pkg::OPC_STORE;
			2: word[6:0] = ctr_isa_pkg::OPC_BRANCH;
			default: begin
				word[6:0] = ctr_isa_pkg::OPC_OP;
				// half of the OP words go to the M extension
				if (word[25]) begin
					word[31:25] = ctr_isa_pkg::FUNCT7_MULDIV;
				end
			end
		endcase
		if (({$random(seed)} % 4) == 0) begin
			b = 32'd0;
		end
		if (({$random(seed)} % 4) == 0) begin
			a = b;
		end
	endtask

	task automatic compare_output(input expect_t e);
		check_value("obs_pc_o", obs_pc, e.pc);
		check_value("obs_class_o", 32'(obs_class), 32'(e.cls));
		check_value("obs_addr_o", obs_addr, e.addr);
		check_value("obs_split_o", 32'(obs_split), 32'(e.split));
		check_value("obs_taken_o", 32'(obs_taken), 32'(e.taken));
		check_value("obs_div_zero_o", 32'(obs_div_zero), 32'(e.div_zero));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d items seen",
				cycle_count, n_received, N_ITEMS));
		end
	end

	initial begin
		expect_t     item;
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		in_valid  = 1'b0;
		instr     = '0;
		rs1       = '0;
		rs2       = '0;
		pc        = '0;
		obs_ready = 1'b0;
		wait (rst_n === 1'b1);
		@(posedge clk);
		// empty and open before the first input
		check_value("obs_valid_o", 32'(obs_valid), 32'd0);
		check_value("in_ready_o", 32'(in_ready), 32'd1);
		while (n_received < N_ITEMS) begin
			// output side first so an empty queue is caught
			if (obs_valid && obs_ready) begin
				if (expected_q.size() == 0) begin
					stop_with_failure("output handshake with no item outstanding");
				end else begin
					item = expected_q.pop_front();
					compare_output(item);
					if (n_received < N_FULL_READY) begin
						check_value("obs_valid_o latency", cycle_count - item.accept_cycle, 2);
					end
					n_received++;
				end
			end
			if (in_valid && in_ready) begin
				item = predict(instr, rs1, rs2, pc);
				item.accept_cycle = cycle_count;
				expected_q.push_back(item);
				n_sent++;
			end
			// a stalled item is held as it is
			if (!(in_valid && !in_ready)) begin
				if (n_sent < N_ITEMS && ({$random(seed)} % 4) != 0) begin
					make_item(word, a, b);
					in_valid <= 1'b1;
					instr    <= word;
					rs1      <= a;
					rs2      <= b;
					pc       <= next_pc;
					next_pc  = next_pc + 32'd4;
				end else begin
					in_valid <= 1'b0;
				end
			end
			if (n_received < N_FULL_READY) begin
				obs_ready <= 1'b1;
			end else begin
				obs_ready <= ({$random(seed)} % 3) != 0;
			end
			@(posedge clk);
		end
		in_valid  <= 1'b0;
		obs_ready <= 1'b1;
		// nothing may follow the last item
		repeat (4) begin
			@(posedge clk);
			if (obs_valid) begin
				stop_with_failure("extra output after all items were observed");
			end
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held for five rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/ctr_observer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_observer (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  logic                            in_valid_i,
	output logic                            in_ready_o,
	input  logic [ctr_isa_pkg::XLEN-1:0]    instr_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    rs1_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    rs2_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    pc_i,
	output logic                            obs_valid_o,
	input  logic                            obs_ready_i,
	output logic [ctr_isa_pkg::XLEN-1:0]    obs_pc_o,
	output logic [ctr_obs_pkg::CLASS_W-1:0] obs_class_o,
	output logic [ctr_isa_pkg::XLEN-1:0]    obs_addr_o,
	output logic                            obs_split_o,
	output logic                            obs_taken_o,
	output logic                            obs_div_zero_o
);

	// decode to execute
	logic                            dec_valid;
	logic                            ex_ready;
	logic [ctr_obs_pkg::CLASS_W-1:0] dec_class;
	logic [2:0]                      dec_funct3;
	logic [ctr_isa_pkg::XLEN-1:0]    dec_imm;
	logic [ctr_isa_pkg::XLEN-1:0]    dec_rs1;
	logic [ctr_isa_pkg::XLEN-1:0]    dec_rs2;
	logic [ctr_isa_pkg::XLEN-1:0]    dec_pc;

	ctr_decode u_decode (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.instr_i      (instr_i),
		.rs1_i        (rs1_i),
		.rs2_i        (rs2_i),
		.pc_i         (pc_i),
		.dec_valid_o  (dec_valid),
		.ex_ready_i   (ex_ready),
		.dec_class_o  (dec_class),
		.dec_funct3_o (dec_funct3),
		.dec_imm_o    (dec_imm),
		.dec_rs1_o    (dec_rs1),
		.dec_rs2_o    (dec_rs2),
		.dec_pc_o     (dec_pc)
	);

	ctr_execute u_execute (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.dec_valid_i    (dec_valid),
		.ex_ready_o     (ex_ready),
		.dec_class_i    (dec_class),
		.dec_funct3_i   (dec_funct3),
		.dec_imm_i      (dec_imm),
		.dec_rs1_i      (dec_rs1),
		.dec_rs2_i      (dec_rs2),
		.dec_pc_i       (dec_pc),
		.obs_valid_o    (obs_valid_o),
		.obs_ready_i    (obs_ready_i),
		.obs_pc_o       (obs_pc_o),
		.obs_class_o    (obs_class_o),
		.obs_addr_o     (obs_addr_o),
		.obs_split_o    (obs_split_o),
		.obs_taken_o    (obs_taken_o),
		.obs_div_zero_o (obs_div_zero_o)
	);

endmodule

`default_nettype wire

// ==== source/ctr_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_execute (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  logic                            dec_valid_i,
	output logic                            ex_ready_o,
	input  logic [ctr_obs_pkg::CLASS_W-1:0] dec_class_i,
	input  logic [2:0]                      dec_funct3_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    dec_imm_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    dec_rs1_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    dec_rs2_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    dec_pc_i,
	output logic                            obs_valid_o,
	input  logic                            obs_ready_i,
	output logic [ctr_isa_pkg::XLEN-1:0]    obs_pc_o,
	output logic [ctr_obs_pkg::CLASS_W-1:0] obs_class_o,
	output logic [ctr_isa_pkg::XLEN-1:0]    obs_addr_o,
	output logic                            obs_split_o,
	output logic                            obs_taken_o,
	output logic                            obs_div_zero_o
);

	logic [ctr_isa_pkg::XLEN-1:0] addr;
	logic                         split;
	logic                         taken;
	logic                         div_zero;
	logic                         ex_accept;

	ctr_lsu_addr u_lsu_addr (
		.class_i  (dec_class_i),
		.funct3_i (dec_funct3_i),
		.base_i   (dec_rs1_i),
		.imm_i    (dec_imm_i),
		.addr_o   (addr),
		.split_o  (split)
	);

	ctr_branch_cmp u_branch_cmp (
		.class_i  (dec_class_i),
		.funct3_i (dec_funct3_i),
		.op_a_i   (dec_rs1_i),
		.op_b_i   (dec_rs2_i),
		.taken_o  (taken)
	);

	// divisor check for every divide and remainder form
	assign div_zero = (dec_class_i == ctr_obs_pkg::CLS_DIV) && (dec_rs2_i == '0);

	assign ex_ready_o = ~obs_valid_o | obs_ready_i;
	assign ex_accept  = dec_valid_i & ex_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			obs_valid_o <= 1'b0;
		end else if (ex_ready_o) begin
			obs_valid_o <= dec_valid_i;
		end
	end

	// output register
	always_ff @(posedge clk_i) begin
		if (ex_accept) begin
			obs_pc_o       <= dec_pc_i;
			obs_class_o    <= dec_class_i;
			obs_addr_o     <= addr;
			obs_split_o    <= split;
			obs_taken_o    <= taken;
			obs_div_zero_o <= div_zero;
		end
	end

	a_obs_stable: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		obs_valid_o && !obs_ready_i |=> obs_valid_o &&
			$stable({obs_pc_o, obs_class_o, obs_addr_o,
				obs_split_o, obs_taken_o, obs_div_zero_o})
	) else $error("observation changed under back-pressure");

	// split comes from the address unit and must only mark memory accesses
	a_split_mem: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		obs_valid_o && obs_split_o |->
			(obs_class_o == ctr_obs_pkg::CLS_LOAD) ||
			(obs_class_o == ctr_obs_pkg::CLS_STORE)
	) else $error("split reported for a non-memory class");

endmodule

`default_nettype wire

// ==== source/ctr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_decode (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              in_valid_i,
	output logic                              in_ready_o,
	input  logic [ctr_isa_pkg::XLEN-1:0]      instr_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]      rs1_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]      rs2_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]      pc_i,
	output logic                              dec_valid_o,
	input  logic                              ex_ready_i,
	output logic [ctr_obs_pkg::CLASS_W-1:0]   dec_class_o,
	output logic [2:0]                        dec_funct3_o,
	output logic [ctr_isa_pkg::XLEN-1:0]      dec_imm_o,
	output logic [ctr_isa_pkg::XLEN-1:0]      dec_rs1_o,
	output logic [ctr_isa_pkg::XLEN-1:0]      dec_rs2_o,
	output logic [ctr_isa_pkg::XLEN-1:0]      dec_pc_o
);

	ctr_isa_pkg::instr_u instr;

	logic [ctr_obs_pkg::CLASS_W-1:0] cls_d;
	logic [ctr_isa_pkg::XLEN-1:0]    imm_i_type;
	logic [ctr_isa_pkg::XLEN-1:0]    imm_s_type;
	logic [ctr_isa_pkg::XLEN-1:0]    imm_d;
	logic                            in_accept;

	assign instr = instr_i;

	// classify by opcode, then funct7 and funct3 for the M extension
	always_comb begin
		cls_d = ctr_obs_pkg::CLS_OTHER;
		case (instr.itype.opcode)
			ctr_isa_pkg::OPC_LOAD: begin
				cls_d = ctr_obs_pkg::CLS_LOAD;
			end
			ctr_isa_pkg::OPC_STORE: begin
				cls_d = ctr_obs_pkg::CLS_STORE;
			end
			ctr_isa_pkg::OPC_BRANCH: begin
				cls_d = ctr_obs_pkg::CLS_BRANCH;
			end
			ctr_isa_pkg::OPC_OP: begin
				if (instr.stype.imm_hi == ctr_isa_pkg::FUNCT7_MULDIV) begin
					// mulh variants stay in the other class
					if (instr.itype.funct3 == ctr_isa_pkg::FUNCT3_MUL) begin
						cls_d = ctr_obs_pkg::CLS_MUL;
					end else if (instr.itype.funct3[2]) begin
						cls_d = ctr_obs_pkg::CLS_DIV;
					end
				end
			end
			default: begin
				cls_d = ctr_obs_pkg::CLS_OTHER;
			end
		endcase
	end

	// sign-extended immediates of both layouts
	assign imm_i_type = {{(ctr_isa_pkg::XLEN - 12){instr.itype.imm[11]}}, instr.itype.imm};
	assign imm_s_type = {{(ctr_isa_pkg::XLEN - 12){instr.stype.imm_hi[6]}},
		instr.stype.imm_hi, instr.stype.imm_lo};

	always_comb begin
		case (cls_d)
			ctr_obs_pkg::CLS_LOAD:  imm_d = imm_i_type;
			ctr_obs_pkg::CLS_STORE: imm_d = imm_s_type;
			default:                imm_d = '0;
		endcase
	end

	// stage is free when empty or when execute takes the held item
	assign in_ready_o = ~dec_valid_o | ex_ready_i;
	assign in_accept  = in_valid_i & in_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			dec_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_accept) begin
			dec_class_o  <= cls_d;
			dec_funct3_o <= instr.itype.funct3;
			dec_imm_o    <= imm_d;
			dec_rs1_o    <= rs1_i;
			dec_rs2_o    <= rs2_i;
			dec_pc_o     <= pc_i;
		end
	end

	// a stalled item must not change class before execute takes it
	a_dec_hold: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		dec_valid_o && !ex_ready_i |=> dec_valid_o && $stable(dec_class_o)
	) else $error("decode item changed while stalled");

endmodule

`default_nettype wire

// ==== source/ctr_branch_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_branch_cmp (
	input  logic [ctr_obs_pkg::CLASS_W-1:0] class_i,
	input  logic [2:0]                      funct3_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    op_a_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    op_b_i,
	output logic                            taken_o
);

	logic [ctr_isa_pkg::XLEN-1:0] diff;
	logic                         is_equal;
	logic                         is_greater_equal;
	logic                         cmp_signed;
	logic                         cmp_result;

	// a - b through the inverted operand and a carry in
	assign diff = op_a_i + ~op_b_i + 1'b1;

	assign is_equal = (diff == '0);

	assign cmp_signed = (funct3_i == ctr_obs_pkg::BR_LT) ||
		(funct3_i == ctr_obs_pkg::BR_GE);

	// same signs cannot overflow, so the difference sign decides
	always_comb begin
		if (op_a_i[ctr_isa_pkg::XLEN-1] == op_b_i[ctr_isa_pkg::XLEN-1]) begin
			is_greater_equal = ~diff[ctr_isa_pkg::XLEN-1];
		end else begin
			// differing signs, a negative a is small only when signed
			is_greater_equal = op_a_i[ctr_isa_pkg::XLEN-1] ^ cmp_signed;
		end
	end

	always_comb begin
		case (funct3_i)
			ctr_obs_pkg::BR_EQ:  cmp_result = is_equal;
			ctr_obs_pkg::BR_NE:  cmp_result = ~is_equal;
			ctr_obs_pkg::BR_LT,
			ctr_obs_pkg::BR_LTU: cmp_result = ~is_greater_equal;
			ctr_obs_pkg::BR_GE,
			ctr_obs_pkg::BR_GEU: cmp_result = is_greater_equal;
			// undefined 010 and 011 fall back to equal
			default:             cmp_result = is_equal;
		endcase
	end

	assign taken_o = (class_i == ctr_obs_pkg::CLS_BRANCH) & cmp_result;

endmodule

`default_nettype wire

// ==== source/ctr_lsu_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctr_lsu_addr (
	input  logic [ctr_obs_pkg::CLASS_W-1:0] class_i,
	input  logic [2:0]                      funct3_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    base_i,
	input  logic [ctr_isa_pkg::XLEN-1:0]    imm_i,
	output logic [ctr_isa_pkg::XLEN-1:0]    addr_o,
	output logic                            split_o
);

	logic       mem_op;
	logic [1:0] size;
	logic [1:0] offset;
	logic       misaligned;

	// effective address, imm is zero outside loads and stores
	assign addr_o = base_i + imm_i;
	assign offset = addr_o[1:0];

	assign mem_op = (class_i == ctr_obs_pkg::CLS_LOAD) ||
		(class_i == ctr_obs_pkg::CLS_STORE);

	// reserved size code 11 is handled as a word
	assign size = (funct3_i[1:0] == 2'b11) ? ctr_obs_pkg::SIZE_WORD : funct3_i[1:0];

	always_comb begin
		case (size)
			ctr_obs_pkg::SIZE_BYTE: misaligned = 1'b0;
			// a halfword only crosses a word at offset 3
			ctr_obs_pkg::SIZE_HALF: misaligned = (offset == 2'b11);
			ctr_obs_pkg::SIZE_WORD: misaligned = (offset != 2'b00);
			default:                misaligned = 1'b0;
		endcase
	end

	assign split_o = mem_op & misaligned;

endmodule

`default_nettype wire

// ==== source/ctr_obs_pkg.sv ====
`default_nettype none

package ctr_obs_pkg;

	// observation class
	localparam int unsigned CLASS_W = 3;

	localparam logic [CLASS_W-1:0] CLS_OTHER  = 3'd0;
	localparam logic [CLASS_W-1:0] CLS_LOAD   = 3'd1;
	localparam logic [CLASS_W-1:0] CLS_STORE  = 3'd2;
	localparam logic [CLASS_W-1:0] CLS_BRANCH = 3'd3;
	localparam logic [CLASS_W-1:0] CLS_MUL    = 3'd4;
	localparam logic [CLASS_W-1:0] CLS_DIV    = 3'd5;

	// access size from funct3[1:0], code 11 counts as a word
	localparam logic [1:0] SIZE_BYTE = 2'b00;
	localparam logic [1:0] SIZE_HALF = 2'b01;
	localparam logic [1:0] SIZE_WORD = 2'b10;

	// branch conditions as encoded in funct3
	localparam logic [2:0] BR_EQ  = 3'b000;
	localparam logic [2:0] BR_NE  = 3'b001;
	localparam logic [2:0] BR_LT  = 3'b100;
	localparam logic [2:0] BR_GE  = 3'b101;
	localparam logic [2:0] BR_LTU = 3'b110;
	localparam logic [2:0] BR_GEU = 3'b111;

endpackage

`default_nettype wire

// ==== source/ctr_isa_pkg.sv ====
`default_nettype none

package ctr_isa_pkg;

	// RV32 data and address width
	localparam int unsigned XLEN = 32;

	// major opcodes seen by the observer
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_OP     = 7'h33;

	// M extension selector in funct7
	localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

	// plain MUL in the M extension
	localparam logic [2:0] FUNCT3_MUL = 3'b000;

	// one instruction word read through two field layouts
	typedef union packed {
		// loads and register-immediate forms
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} itype;
		// stores; imm_hi is also funct7 for register-register forms
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} stype;
	} instr_u;

endpackage

`default_nettype wire
